// File: source/dcache_pkg.sv
package dcache_pkg;

    // ------------------------------------------------------------------------
    // cache geometry
    // ------------------------------------------------------------------------
    localparam int unsigned addr_width      = 32;
    localparam int unsigned word_width      = 64;
    // a line holds two core words
    localparam int unsigned line_width      = 128;
    localparam int unsigned num_ways        = 2;
    localparam int unsigned num_sets        = 16;
    // derived address split: tag | index | offset
    localparam int unsigned offset_width    = $clog2(line_width / 8);
    localparam int unsigned index_width     = $clog2(num_sets);
    localparam int unsigned tag_width       = addr_width - index_width - offset_width;
    localparam int unsigned line_addr_width = addr_width - offset_width;

    // ------------------------------------------------------------------------
    // bus and array types
    // ------------------------------------------------------------------------
    typedef logic [line_width-1:0] line_t;

    // core side, one word per request
    typedef struct packed {
        logic                      valid;
        logic                      we;
        logic [addr_width-1:0]     addr;
        logic [word_width/8-1:0]   be;
        logic [word_width-1:0]     wdata;
    } core_req_t;

    typedef struct packed {
        logic                  gnt;
        logic                  rvalid;
        logic [word_width-1:0] rdata;
    } core_rsp_t;

    // memory side moves whole lines
    typedef struct packed {
        logic                       valid;
        logic                       we;
        logic [line_addr_width-1:0] line_addr;
        line_t                      wline;
    } mem_req_t;

    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        line_t rline;
    } mem_rsp_t;

    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [tag_width-1:0] tag;
    } tag_entry_t;

    // one access broadcast to all ways, en picks the ways that take part
    typedef struct packed {
        logic [num_ways-1:0]    en;
        logic                   we;
        logic [index_width-1:0] index;
        tag_entry_t             entry;
        line_t                  line;
    } arr_req_t;

endpackage

// File: source/dcache_sram.sv
module dcache_sram #(
    parameter type entry_t = logic
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                en_i,
    input  logic                                we_i,
    input  logic [dcache_pkg::index_width-1:0]  index_i,
    input  entry_t                              wdata_i,
    output entry_t                              rdata_o
);

    // one entry per set
    entry_t mem_q [dcache_pkg::num_sets];

    // single port, whole-entry writes
    // read data is registered and holds until the next read
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            // clearing here leaves every tag entry invalid
            mem_q   <= '{default: '0};
            rdata_o <= '0;
        end else if (en_i) begin
            if (we_i) begin
                mem_q[index_i] <= wdata_i;
            end else begin
                rdata_o <= mem_q[index_i];
            end
        end
    end

endmodule

// File: source/dcache_lookup.sv
module dcache_lookup (
    input  logic                                                clk_i,
    input  logic                                                rst_ni,
    input  logic [dcache_pkg::tag_width-1:0]                    tag_i,
    input  dcache_pkg::tag_entry_t [dcache_pkg::num_ways-1:0]   entries_i,
    input  dcache_pkg::line_t [dcache_pkg::num_ways-1:0]        lines_i,
    input  logic                                                refill_i,
    output logic [dcache_pkg::num_ways-1:0]                     hit_way_o,
    output dcache_pkg::line_t                                   hit_line_o,
    output logic [dcache_pkg::num_ways-1:0]                     victim_way_o,
    output dcache_pkg::tag_entry_t                              victim_entry_o,
    output dcache_pkg::line_t                                   victim_line_o
);

    // round-robin pointer, used once all ways of the set are valid
    logic [$clog2(dcache_pkg::num_ways)-1:0] rr_q;

    // ------------------------------------------------------------------------
    // tag compare and hit mux
    // ------------------------------------------------------------------------
    always_comb begin
        hit_line_o = '0;
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            hit_way_o[w] = entries_i[w].valid && (entries_i[w].tag == tag_i);
            // one-hot, so an or-mux is enough
            if (hit_way_o[w]) begin
                hit_line_o = hit_line_o | lines_i[w];
            end
        end
    end

    // ------------------------------------------------------------------------
    // victim choice
    // ------------------------------------------------------------------------
    always_comb begin
        victim_way_o       = '0;
        victim_way_o[rr_q] = 1'b1;
        // walk down so the lowest invalid way wins
        for (int w = dcache_pkg::num_ways - 1; w >= 0; w--) begin
            if (!entries_i[w].valid) begin
                victim_way_o    = '0;
                victim_way_o[w] = 1'b1;
            end
        end
        victim_entry_o = '0;
        victim_line_o  = '0;
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            if (victim_way_o[w]) begin
                victim_entry_o = entries_i[w];
                victim_line_o  = lines_i[w];
            end
        end
    end

    // pointer moves on every refill write
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rr_q <= '0;
        end else if (refill_i) begin
            rr_q <= (rr_q == dcache_pkg::num_ways - 1) ? '0 : rr_q + 1'b1;
        end
    end

endmodule

// File: source/dcache_ctrl.sv
module dcache_ctrl (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  dcache_pkg::core_req_t               core_req_i,
    output dcache_pkg::core_rsp_t               core_rsp_o,
    output logic                                busy_o,
    output dcache_pkg::arr_req_t                arr_req_o,
    input  logic [dcache_pkg::num_ways-1:0]     hit_way_i,
    input  dcache_pkg::line_t                   hit_line_i,
    input  logic [dcache_pkg::num_ways-1:0]     victim_way_i,
    input  dcache_pkg::tag_entry_t              victim_entry_i,
    input  dcache_pkg::line_t                   victim_line_i,
    output logic                                refill_o,
    output logic [dcache_pkg::tag_width-1:0]    req_tag_o,
    output dcache_pkg::mem_req_t                mem_req_o,
    input  dcache_pkg::mem_rsp_t                mem_rsp_i
);

    typedef enum logic [2:0] {
        s_idle,
        s_lookup,
        s_store_write,
        s_wb_req,
        s_refill_req,
        s_refill_wait,
        s_refill_write
    } state_e;

    state_e                                 state_d, state_q;
    dcache_pkg::core_req_t                  req_d, req_q;
    dcache_pkg::line_t                      line_d, line_q;
    logic [dcache_pkg::num_ways-1:0]        way_d, way_q;
    logic [dcache_pkg::index_width-1:0]     req_index;
    logic                                   word_sel;
    dcache_pkg::line_t                      rd_line;

    // overlay the store bytes onto one word of a line
    function automatic dcache_pkg::line_t merge_word(
        input dcache_pkg::line_t                 line,
        input logic                              sel,
        input logic [dcache_pkg::word_width/8-1:0] be,
        input logic [dcache_pkg::word_width-1:0] wdata
    );
        dcache_pkg::line_t merged;
        merged = line;
        for (int b = 0; b < dcache_pkg::word_width / 8; b++) begin
            if (be[b]) begin
                merged[sel * dcache_pkg::word_width + b * 8 +: 8] = wdata[b * 8 +: 8];
            end
        end
        return merged;
    endfunction

    // fields of the registered request
    assign req_index = req_q.addr[dcache_pkg::offset_width +: dcache_pkg::index_width];
    assign req_tag_o = req_q.addr[dcache_pkg::addr_width-1 -: dcache_pkg::tag_width];
    // address bit 3 picks the word inside the line
    assign word_sel  = req_q.addr[dcache_pkg::offset_width-1];

    assign busy_o   = (state_q != s_idle);
    assign refill_o = (state_q == s_refill_write);
    // hits read straight from the arrays, misses from the refill buffer
    assign rd_line  = (state_q == s_lookup) ? hit_line_i : line_q;

    // ------------------------------------------------------------------------
    // cache FSM
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        req_d   = req_q;
        line_d  = line_q;
        way_d   = way_q;

        core_rsp_o       = '0;
        core_rsp_o.rdata = rd_line[word_sel * dcache_pkg::word_width +: dcache_pkg::word_width];
        arr_req_o        = '0;
        arr_req_o.index  = req_index;
        mem_req_o        = '0;

        case (state_q)
            s_idle: begin
                arr_req_o.index = core_req_i.addr[dcache_pkg::offset_width +:
                                                  dcache_pkg::index_width];
                // accept and read all ways at once
                if (core_req_i.valid) begin
                    core_rsp_o.gnt = 1'b1;
                    arr_req_o.en   = '1;
                    req_d          = core_req_i;
                    state_d        = s_lookup;
                end
            end
            s_lookup: begin
                if (|hit_way_i) begin
                    way_d = hit_way_i;
                    if (req_q.we) begin
                        // store needs a second array access
                        state_d = s_store_write;
                    end else begin
                        core_rsp_o.rvalid = 1'b1;
                        state_d           = s_idle;
                    end
                end else begin
                    // miss, the victim way takes the refilled line
                    way_d = victim_way_i;
                    if (victim_entry_i.valid && victim_entry_i.dirty) begin
                        state_d = s_wb_req;
                    end else begin
                        state_d = s_refill_req;
                    end
                end
            end
            s_store_write: begin
                arr_req_o.en          = way_q;
                arr_req_o.we          = 1'b1;
                arr_req_o.entry.valid = 1'b1;
                arr_req_o.entry.dirty = 1'b1;
                arr_req_o.entry.tag   = req_tag_o;
                arr_req_o.line = merge_word(hit_line_i, word_sel, req_q.be, req_q.wdata);
                state_d               = s_idle;
            end
            s_wb_req: begin
                // arrays are idle here, so the victim outputs stay put
                mem_req_o.valid     = 1'b1;
                mem_req_o.we        = 1'b1;
                mem_req_o.line_addr = {victim_entry_i.tag, req_index};
                mem_req_o.wline     = victim_line_i;
                if (mem_rsp_i.gnt) begin
                    state_d = s_refill_req;
                end
            end
            s_refill_req: begin
                mem_req_o.valid     = 1'b1;
                mem_req_o.line_addr = req_q.addr[dcache_pkg::addr_width-1:
                                                 dcache_pkg::offset_width];
                if (mem_rsp_i.gnt) begin
                    state_d = s_refill_wait;
                end
            end
            s_refill_wait: begin
                if (mem_rsp_i.rvalid) begin
                    line_d  = mem_rsp_i.rline;
                    state_d = s_refill_write;
                end
            end
            s_refill_write: begin
                arr_req_o.en          = way_q;
                arr_req_o.we          = 1'b1;
                arr_req_o.entry.valid = 1'b1;
                // a store miss leaves the line dirty
                arr_req_o.entry.dirty = req_q.we;
                arr_req_o.entry.tag   = req_tag_o;
                arr_req_o.line = merge_word(line_q, word_sel, req_q.we ? req_q.be : '0,
                                            req_q.wdata);
                core_rsp_o.rvalid     = !req_q.we;
                state_d               = s_idle;
            end
            default: begin
                state_d = s_idle;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= s_idle;
            way_q   <= '0;
        end else begin
            state_q <= state_d;
            way_q   <= way_d;
        end
    end

    // request and refill payload
    always_ff @(posedge clk_i) begin
        req_q  <= req_d;
        line_q <= line_d;
    end

endmodule

// File: source/dcache_top.sv
module dcache_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  dcache_pkg::core_req_t   core_req_i,
    output dcache_pkg::core_rsp_t   core_rsp_o,
    output logic                    busy_o,
    output dcache_pkg::mem_req_t    mem_req_o,
    input  dcache_pkg::mem_rsp_t    mem_rsp_i
);

    dcache_pkg::arr_req_t                                   arr_req;
    dcache_pkg::tag_entry_t [dcache_pkg::num_ways-1:0]      entries;
    dcache_pkg::line_t [dcache_pkg::num_ways-1:0]           lines;
    logic [dcache_pkg::num_ways-1:0]                        hit_way;
    dcache_pkg::line_t                                      hit_line;
    logic [dcache_pkg::num_ways-1:0]                        victim_way;
    dcache_pkg::tag_entry_t                                 victim_entry;
    dcache_pkg::line_t                                      victim_line;
    logic                                                   refill;
    logic [dcache_pkg::tag_width-1:0]                       req_tag;

    dcache_ctrl ctrl_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .core_req_i     (core_req_i),
        .core_rsp_o     (core_rsp_o),
        .busy_o         (busy_o),
        .arr_req_o      (arr_req),
        .hit_way_i      (hit_way),
        .hit_line_i     (hit_line),
        .victim_way_i   (victim_way),
        .victim_entry_i (victim_entry),
        .victim_line_i  (victim_line),
        .refill_o       (refill),
        .req_tag_o      (req_tag),
        .mem_req_o      (mem_req_o),
        .mem_rsp_i      (mem_rsp_i)
    );

    dcache_lookup lookup_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .tag_i          (req_tag),
        .entries_i      (entries),
        .lines_i        (lines),
        .refill_i       (refill),
        .hit_way_o      (hit_way),
        .hit_line_o     (hit_line),
        .victim_way_o   (victim_way),
        .victim_entry_o (victim_entry),
        .victim_line_o  (victim_line)
    );

    // ------------------------------------------------------------------------
    // per-way tag and data arrays
    // ------------------------------------------------------------------------
    for (genvar w = 0; w < dcache_pkg::num_ways; w++) begin : gen_way
        dcache_sram #(.entry_t(dcache_pkg::tag_entry_t)) tag_sram_inst (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .en_i    (arr_req.en[w]),
            .we_i    (arr_req.we),
            .index_i (arr_req.index),
            .wdata_i (arr_req.entry),
            .rdata_o (entries[w])
        );

        dcache_sram #(.entry_t(dcache_pkg::line_t)) data_sram_inst (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .en_i    (arr_req.en[w]),
            .we_i    (arr_req.we),
            .index_i (arr_req.index),
            .wdata_i (arr_req.line),
            .rdata_o (lines[w])
        );
    end

endmodule

// File: testbench/tb_dcache_mem.sv
module tb_dcache_mem (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  dcache_pkg::mem_req_t    mem_req_i,
    output dcache_pkg::mem_rsp_t    mem_rsp_o,
    // reference words of the tested range, indexed by address bits 9:3
    input  logic [63:0]             ref_words_i [128],
    output int                      errors_o
);

    // lines written back so far, every other line keeps its initial pattern
    dcache_pkg::line_t lines [logic [dcache_pkg::line_addr_width-1:0]];

    // untouched memory: each word equals its own byte address
    function automatic dcache_pkg::line_t read_line(
        input logic [dcache_pkg::line_addr_width-1:0] line_addr
    );
        if (lines.exists(line_addr)) begin
            return lines[line_addr];
        end
        return {32'h0, line_addr, 4'h8, 32'h0, line_addr, 4'h0};
    endfunction

    initial begin
        dcache_pkg::mem_req_t                   held;
        dcache_pkg::mem_rsp_t                   rsp;
        dcache_pkg::line_t                      expected;
        logic [dcache_pkg::line_addr_width-1:0] rd_addr;
        logic                                   waiting;
        logic                                   pending;
        int unsigned                            gnt_wait;
        int unsigned                            rv_wait;
        mem_rsp_o = '0;
        errors_o  = 0;
        held      = '0;
        rd_addr   = '0;
        waiting   = 1'b0;
        pending   = 1'b0;
        gnt_wait  = 0;
        rv_wait   = 0;
        forever begin
            @(posedge clk_i);
            #2;
            rsp = '0;
            if (!rst_ni) begin
                waiting = 1'b0;
                pending = 1'b0;
            end else if (pending) begin
                // read data returns a random number of cycles after its grant
                if (rv_wait == 0) begin
                    rsp.rvalid = 1'b1;
                    rsp.rline  = read_line(rd_addr);
                    pending    = 1'b0;
                end else begin
                    rv_wait--;
                end
            end else if (mem_req_i.valid || waiting) begin
                assert (!waiting || mem_req_i == held) else begin
                    $display("memory request changed while its grant was held low");
                    errors_o++;
                end
                // new request, pick how long to hold the grant back
                if (!waiting) begin
                    gnt_wait = $urandom_range(3, 0);
                end
                waiting = (gnt_wait != 0);
                held    = mem_req_i;
                if (gnt_wait != 0) begin
                    gnt_wait--;
                end else begin
                    rsp.gnt = 1'b1;
                    if (mem_req_i.we) begin
                        // write-back has to carry everything stored to that line
                        expected = {ref_words_i[{mem_req_i.line_addr[5:0], 1'b1}],
                                    ref_words_i[{mem_req_i.line_addr[5:0], 1'b0}]};
                        assert (mem_req_i.wline == expected) else begin
                            $display("[ERROR] mem_req.wline: got %h expected %h",
                                     mem_req_i.wline, expected);
                            errors_o++;
                        end
                        lines[mem_req_i.line_addr] = mem_req_i.wline;
                    end else begin
                        pending = 1'b1;
                        rv_wait = $urandom_range(3, 0);
                        rd_addr = mem_req_i.line_addr;
                    end
                end
            end
            mem_rsp_o = rsp;
        end
    end

endmodule

// File: testbench/tb_dcache_top.sv
module tb_dcache_top;

    logic                   clk;
    logic                   rst_n;
    dcache_pkg::core_req_t  core_req;
    dcache_pkg::core_rsp_t  core_rsp;
    logic                   busy;
    dcache_pkg::mem_req_t   mem_req;
    dcache_pkg::mem_rsp_t   mem_rsp;
    // expected memory image, tags 0..2 keep all tested addresses below 0x300
    logic [63:0]            ref_words [128];
    logic [27:0]            last_line;
    int                     errors;
    int                     mem_errors;

    dcache_top dcache_top_inst (
        .clk_i      (clk),
        .rst_ni     (rst_n),
        .core_req_i (core_req),
        .core_rsp_o (core_rsp),
        .busy_o     (busy),
        .mem_req_o  (mem_req),
        .mem_rsp_i  (mem_rsp)
    );

    tb_dcache_mem mem_inst (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .mem_req_i   (mem_req),
        .mem_rsp_o   (mem_rsp),
        .ref_words_i (ref_words),
        .errors_o    (mem_errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // tag 0..2, set 3 or 9, word 0 or 1
    function automatic logic [31:0] make_addr(input int unsigned tag, input int unsigned set_sel,
                                              input int unsigned word);
        logic [31:0] addr;
        addr      = '0;
        addr[9:8] = tag[1:0];
        addr[7:4] = set_sel[0] ? 4'd9 : 4'd3;
        addr[3]   = word[0];
        return addr;
    endfunction

    task automatic check_quiet(input string phase);
        assert (!core_rsp.gnt && !core_rsp.rvalid && !mem_req.valid && !busy) else begin
            $display("[ERROR] outputs %s: gnt=%h rvalid=%h mem_req.valid=%h busy=%h",
                     phase, core_rsp.gnt, core_rsp.rvalid, mem_req.valid, busy);
            errors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // one core request, from valid to busy falling
    // ------------------------------------------------------------------------
    task automatic run_request(input logic we, input logic [31:0] addr, input logic [7:0] be,
                               input logic [63:0] wdata);
        logic [6:0]  idx;
        logic        same_line;
        int unsigned cycles;
        int unsigned rv_count;
        int unsigned rv_cycle;
        idx            = addr[9:3];
        same_line      = (addr[31:4] == last_line);
        core_req.valid = 1'b1;
        core_req.we    = we;
        core_req.addr  = addr;
        core_req.be    = be;
        core_req.wdata = wdata;
        cycles         = 0;
        @(negedge clk);
        while (!core_rsp.gnt && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        assert (core_rsp.gnt) else begin
            $display("no grant within 20 cycles for address %h", addr);
            errors++;
        end
        // accepted, so the expected image takes the store bytes now
        if (we) begin
            for (int b = 0; b < 8; b++) begin
                if (be[b]) begin
                    ref_words[idx][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end
        @(posedge clk);
        #2;
        core_req.valid = 1'b0;
        rv_count       = 0;
        rv_cycle       = 0;
        cycles         = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (core_rsp.rvalid) begin
                rv_count++;
                rv_cycle = cycles;
                assert (core_rsp.rdata == ref_words[idx]) else begin
                    $display("[ERROR] core_rsp.rdata: got %h expected %h at address %h",
                             core_rsp.rdata, ref_words[idx], addr);
                    errors++;
                end
            end
        end while (busy && cycles < 200);
        assert (!busy) else begin
            $display("request to address %h did not finish within 200 cycles", addr);
            errors++;
        end
        assert (rv_count == (we ? 0 : 1)) else begin
            $display("[ERROR] rvalid count: got %h expected %h", rv_count, !we);
            errors++;
        end
        // the line is still there from the previous request, so this is a hit
        if (!we && same_line) begin
            assert (rv_cycle == 1) else begin
                $display("[ERROR] rvalid latency: got %h expected %h", rv_cycle, 1);
                errors++;
            end
        end
        last_line = addr[31:4];
        @(posedge clk);
        #2;
    endtask

    initial begin
        logic [31:0] addr;
        logic        we;
        void'($urandom(32'h6a51df60));
        errors    = 0;
        rst_n     = 1'b0;
        core_req  = '0;
        last_line = '1;
        for (int i = 0; i < 128; i++) begin
            ref_words[i] = 64'(i) << 3;
        end
        repeat (10) begin
            @(negedge clk);
            check_quiet("during reset");
        end
        @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_quiet("after reset");
        @(posedge clk);
        #2;
        // load miss, load hit, store hit, then store miss, each read back
        run_request(1'b0, make_addr(0, 0, 0), 8'h00, 64'h0);
        run_request(1'b0, make_addr(0, 0, 0), 8'h00, 64'h0);
        run_request(1'b1, make_addr(0, 0, 1), 8'h0f, 64'h1122334455667788);
        run_request(1'b0, make_addr(0, 0, 1), 8'h00, 64'h0);
        run_request(1'b1, make_addr(2, 1, 0), 8'ha5, 64'hdeadbeefcafef00d);
        run_request(1'b0, make_addr(2, 1, 0), 8'h00, 64'h0);
        for (int n = 0; n < 300; n++) begin
            if (n % 4 == 3) begin
                addr = {last_line, 1'($urandom_range(1, 0)), 3'b000};
                we   = 1'b0;
            end else begin
                addr = make_addr($urandom_range(2, 0), $urandom_range(1, 0),
                                 $urandom_range(1, 0));
                we   = ($urandom_range(9, 0) < 4);
            end
            run_request(we, addr, 8'($urandom), {$urandom, $urandom});
        end
        $display("checks done: %0d core errors, %0d memory errors", errors, mem_errors);
        if (errors == 0 && mem_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: all.f
source/dcache_pkg.sv
source/dcache_sram.sv
source/dcache_lookup.sv
source/dcache_ctrl.sv
source/dcache_top.sv
testbench/tb_dcache_mem.sv
testbench/tb_dcache_top.sv

// File: Makefile
TOP := tb_dcache_top

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -o sim
	out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

lint:
	verilator --lint-only -Wall --top-module dcache_top \
		source/dcache_pkg.sv source/dcache_sram.sv source/dcache_lookup.sv \
		source/dcache_ctrl.sv source/dcache_top.sv

clean:
	rm -rf obj_dir
